//--- logic/bp_pkg.sv
package bp_pkg;

// address and fetch geometry
localparam int VADDR_W    = 32;
localparam int LANES      = 2;
localparam int OFFSET_W   = 2;
localparam int ENTRIES    = 64;
localparam int INDEX_W    = $clog2(ENTRIES);
localparam int TAG_W      = VADDR_W - INDEX_W - 1 - OFFSET_W;

// instruction cache line, used for the line-end rule
localparam int LINE_BYTES = 32;
localparam int LINE_OFF_W = $clog2(LINE_BYTES);

// kind of control flow held in a BTB entry
typedef enum logic [1:0] {
	cf_none     = 2'd0,
	cf_branch   = 2'd1,
	cf_jump     = 2'd2,
	cf_indirect = 2'd3
} cf_e;

// two-bit saturating counter, bit 1 set predicts taken
typedef logic [1:0] ctr_t;

localparam ctr_t CTR_MIN   = 2'b00;
localparam ctr_t CTR_RESET = 2'b01;
localparam ctr_t CTR_MAX   = 2'b11;

// field view of a fetch or resolved pc
typedef struct packed {
	logic [TAG_W-1:0]    tag;
	logic [INDEX_W-1:0]  index;
	logic                lane;
	logic [OFFSET_W-1:0] offset;
} vaddr_fields_t;

// same word seen as a whole address or split into fields
typedef union packed {
	logic [VADDR_W-1:0] raw;
	vaddr_fields_t      f;
} vaddr_u;

endpackage

//--- logic/bp_update_router.sv
module bp_update_router (
	// resolved branch from the execute stage
	input  logic                        res_valid,
	input  bp_pkg::vaddr_u              res_pc,
	input  logic [bp_pkg::VADDR_W-1:0]  res_target,
	input  bp_pkg::cf_e                 res_cf,
	input  logic                        res_taken,
	input  bp_pkg::ctr_t                res_counter,

	// per-lane write strobes
	output logic [bp_pkg::LANES-1:0]    btb_we,
	output logic [bp_pkg::LANES-1:0]    bht_we,

	// write data shared by both lanes
	output logic [bp_pkg::INDEX_W-1:0]  wr_index,
	output logic [bp_pkg::TAG_W-1:0]    wr_tag,
	output logic [bp_pkg::VADDR_W-1:0]  wr_target,
	output bp_pkg::cf_e                 wr_cf,
	output bp_pkg::ctr_t                wr_counter
);

import bp_pkg::*;

logic [LANES-1:0] lane_sel;

// one-hot of the slot the branch came from
always_comb begin
	lane_sel = '0;
	lane_sel[res_pc.f.lane] = 1'b1;
end

// every resolved control flow refreshes the BTB
assign btb_we = res_valid ? lane_sel : '0;

// only conditional branches train the counter
assign bht_we = (res_valid && res_cf == cf_branch) ? lane_sel : '0;

assign wr_index  = res_pc.f.index;
assign wr_tag    = res_pc.f.tag;
assign wr_target = res_target;
assign wr_cf     = res_cf;

// step the predicted counter toward the outcome, saturating at both ends
always_comb begin
	if (res_taken) begin
		if (res_counter == CTR_MAX)
			wr_counter = CTR_MAX;
		else
			wr_counter = ctr_t'(res_counter + 2'd1);
	end else begin
		if (res_counter == CTR_MIN)
			wr_counter = CTR_MIN;
		else
			wr_counter = ctr_t'(res_counter - 2'd1);
	end
end

endmodule

//--- logic/bp_lane_bank.sv
module bp_lane_bank (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall,

	// fetch address, only index and tag are looked at
	input  bp_pkg::vaddr_u              pc,

	// update port from the router
	input  logic                        btb_we,
	input  logic                        bht_we,
	input  logic [bp_pkg::INDEX_W-1:0]  wr_index,
	input  logic [bp_pkg::TAG_W-1:0]    wr_tag,
	input  logic [bp_pkg::VADDR_W-1:0]  wr_target,
	input  bp_pkg::cf_e                 wr_cf,
	input  bp_pkg::ctr_t                wr_counter,

	// lookup result, one cycle after pc is sampled
	output bp_pkg::cf_e                 hit_cf,
	output logic [bp_pkg::VADDR_W-1:0]  hit_target,
	output bp_pkg::ctr_t                hit_counter
);

import bp_pkg::*;

// BTB storage
logic [ENTRIES-1:0] btb_valid;
logic [TAG_W-1:0]   btb_tag    [ENTRIES];
logic [VADDR_W-1:0] btb_target [ENTRIES];
cf_e                btb_cf     [ENTRIES];

// BHT storage
ctr_t               bht        [ENTRIES];

// registered read of the entry at the fetch index
logic               rd_valid;
logic [TAG_W-1:0]   rd_tag;
logic [VADDR_W-1:0] rd_target;
cf_e                rd_cf;
ctr_t               rd_counter;
logic [TAG_W-1:0]   fetch_tag;

always_ff @(posedge clk) begin
	if (btb_we) begin
		btb_tag[wr_index]    <= wr_tag;
		btb_target[wr_index] <= wr_target;
		btb_cf[wr_index]     <= wr_cf;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		btb_valid <= '0;
	end else if (btb_we) begin
		btb_valid[wr_index] <= 1'b1;
	end
end

// counters start weakly not taken
always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < ENTRIES; i++) begin
			bht[i] <= CTR_RESET;
		end
	end else if (bht_we) begin
		bht[wr_index] <= wr_counter;
	end
end

// a write at the same edge is seen from the next read on
always_ff @(posedge clk) begin
	if (rst) begin
		rd_valid   <= 1'b0;
		rd_counter <= CTR_RESET;
	end else if (!stall) begin
		rd_valid   <= btb_valid[pc.f.index];
		rd_counter <= bht[pc.f.index];
	end
end

always_ff @(posedge clk) begin
	if (!stall) begin
		rd_tag    <= btb_tag[pc.f.index];
		rd_target <= btb_target[pc.f.index];
		rd_cf     <= btb_cf[pc.f.index];
		fetch_tag <= pc.f.tag;
	end
end

// tag mismatch or empty slot reads as no control flow
assign hit_cf      = (rd_valid && rd_tag == fetch_tag) ? rd_cf : cf_none;
assign hit_target  = rd_target;
assign hit_counter = rd_counter;

endmodule

//--- logic/bp_select.sv
module bp_select (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall,
	input  logic                        flush,
	input  bp_pkg::vaddr_u              pc,

	// lookup results, one per lane
	input  bp_pkg::cf_e                 hit_cf      [bp_pkg::LANES],
	input  logic [bp_pkg::VADDR_W-1:0]  hit_target  [bp_pkg::LANES],
	input  bp_pkg::ctr_t                hit_counter [bp_pkg::LANES],

	// prediction for the pc sampled at the last unstalled edge
	output logic                        pred_valid,
	output logic                        pred_taken,
	output logic [bp_pkg::VADDR_W-1:0]  pred_target,
	output bp_pkg::cf_e                 pred_cf,
	output bp_pkg::ctr_t                pred_counter,
	output logic [bp_pkg::LANES-1:0]    pred_sel
);

import bp_pkg::*;

vaddr_u pc_q;
logic   pipe_flush;
logic   sel_lane;
logic   line_end;

// track the pc the banks are reading for
always_ff @(posedge clk) begin
	if (rst) begin
		pc_q       <= '0;
		pipe_flush <= 1'b0;
	end else if (!stall) begin
		pc_q       <= pc;
		pipe_flush <= flush;
	end
end

// odd slot fetch only holds lane 1, else lane 0 has priority on a hit
assign sel_lane = pc_q.f.lane ? 1'b1 : (hit_cf[0] == cf_none);

// last slot of the line has no delay slot in this fetch
assign line_end = &pc_q.raw[LINE_OFF_W-1:2];

always_comb begin
	pred_sel = '0;
	pred_sel[sel_lane] = 1'b1;
end

assign pred_cf      = hit_cf[sel_lane];
assign pred_target  = hit_target[sel_lane];
assign pred_counter = hit_counter[sel_lane];
assign pred_valid   = (pred_cf != cf_none) && !line_end && !pipe_flush;

// jumps and indirects always go, branches follow the counter
assign pred_taken = (pred_cf == cf_branch) ? pred_counter[1] : 1'b1;

endmodule

//--- logic/branch_predictor.sv
module branch_predictor (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall,
	input  logic                        flush,

	// fetch address of the current instruction pair
	input  bp_pkg::vaddr_u              pc,

	// resolved branch
	input  logic                        res_valid,
	input  bp_pkg::vaddr_u              res_pc,
	input  logic [bp_pkg::VADDR_W-1:0]  res_target,
	input  bp_pkg::cf_e                 res_cf,
	input  logic                        res_taken,
	input  bp_pkg::ctr_t                res_counter,

	// prediction, one cycle after pc
	output logic                        pred_valid,
	output logic                        pred_taken,
	output logic [bp_pkg::VADDR_W-1:0]  pred_target,
	output bp_pkg::cf_e                 pred_cf,
	output bp_pkg::ctr_t                pred_counter,
	output logic [bp_pkg::LANES-1:0]    pred_sel
);

import bp_pkg::*;

logic [LANES-1:0]   btb_we;
logic [LANES-1:0]   bht_we;
logic [INDEX_W-1:0] wr_index;
logic [TAG_W-1:0]   wr_tag;
logic [VADDR_W-1:0] wr_target;
cf_e                wr_cf;
ctr_t               wr_counter;

cf_e                hit_cf      [LANES];
logic [VADDR_W-1:0] hit_target  [LANES];
ctr_t               hit_counter [LANES];

bp_update_router u_router (
	.res_valid   ( res_valid   ),
	.res_pc      ( res_pc      ),
	.res_target  ( res_target  ),
	.res_cf      ( res_cf      ),
	.res_taken   ( res_taken   ),
	.res_counter ( res_counter ),
	.btb_we      ( btb_we      ),
	.bht_we      ( bht_we      ),
	.wr_index    ( wr_index    ),
	.wr_tag      ( wr_tag      ),
	.wr_target   ( wr_target   ),
	.wr_cf       ( wr_cf       ),
	.wr_counter  ( wr_counter  )
);

// one bank per instruction slot
for (genvar i = 0; i < LANES; i++) begin : g_lane
	bp_lane_bank u_bank (
		.clk,
		.rst,
		.stall,
		.pc,
		.btb_we      ( btb_we[i]      ),
		.bht_we      ( bht_we[i]      ),
		.wr_index    ( wr_index       ),
		.wr_tag      ( wr_tag         ),
		.wr_target   ( wr_target      ),
		.wr_cf       ( wr_cf          ),
		.wr_counter  ( wr_counter     ),
		.hit_cf      ( hit_cf[i]      ),
		.hit_target  ( hit_target[i]  ),
		.hit_counter ( hit_counter[i] )
	);
end

bp_select u_select (
	.clk,
	.rst,
	.stall,
	.flush,
	.pc,
	.hit_cf       ( hit_cf       ),
	.hit_target   ( hit_target   ),
	.hit_counter  ( hit_counter  ),
	.pred_valid   ( pred_valid   ),
	.pred_taken   ( pred_taken   ),
	.pred_target  ( pred_target  ),
	.pred_cf      ( pred_cf      ),
	.pred_counter ( pred_counter ),
	.pred_sel     ( pred_sel     )
);

endmodule

//--- dv/tb_branch_predictor.sv
module tb_branch_predictor;

import bp_pkg::*;

localparam int TIMEOUT_CYCLES = 2000;

logic               clk;
logic               rst;
logic               stall;
logic               flush;
vaddr_u             pc;
logic               res_valid;
vaddr_u             res_pc;
logic [VADDR_W-1:0] res_target;
cf_e                res_cf;
logic               res_taken;
ctr_t               res_counter;
logic               pred_valid;
logic               pred_taken;
logic [VADDR_W-1:0] pred_target;
cf_e                pred_cf;
ctr_t               pred_counter;
logic [LANES-1:0]   pred_sel;

integer             seed = 32'hc26f;
int                 cycles = 0;

// expected counter per lane and index
ctr_t               model_ctr [LANES*ENTRIES];

// entries kept for the stall test
vaddr_u             keep_pc;
logic [VADDR_W-1:0] keep_target;
vaddr_u             alias_pc;
logic [VADDR_W-1:0] alias_target;

branch_predictor u_dut (.*);

always #10 clk = ~clk;

always @(posedge clk) begin
	cycles = cycles + 1;
	if (cycles >= TIMEOUT_CYCLES) begin
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$fatal(1);
	end
end

task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		$display("Result: FAILED");
		$fatal(1);
	end
endtask

// inputs change 1 unit after the edge
task automatic tick();
	@(posedge clk);
	#1;
endtask

function automatic ctr_t next_ctr(input ctr_t c, input logic taken);
	if (taken)
		return (c == 2'd3) ? c : c + 2'd1;
	return (c == 2'd0) ? c : c - 2'd1;
endfunction

// last 4-byte slot of a cache line
function automatic logic at_line_end(input vaddr_u a);
	return (a.raw % LINE_BYTES) >= LINE_BYTES - 4;
endfunction

task automatic make_pc(input logic [INDEX_W-1:0] index, input logic lane, output vaddr_u a);
	a.raw      = $random(seed);
	a.f.index  = index;
	a.f.lane   = lane;
	a.f.offset = '0;
endtask

task automatic resolve(input vaddr_u addr, input logic [31:0] target, input cf_e cf,
		input logic taken);
	logic [INDEX_W:0] key;
	key         = {addr.f.lane, addr.f.index};
	res_valid   = 1'b1;
	res_pc      = addr;
	res_target  = target;
	res_cf      = cf;
	res_taken   = taken;
	res_counter = model_ctr[key];
	if (cf == cf_branch)
		model_ctr[key] = next_ctr(model_ctr[key], taken);
	tick();
	res_valid = 1'b0;
endtask

// fetch one pc and check the prediction that follows it
task automatic predict(input vaddr_u fpc, input logic hit, input cf_e cf,
		input logic [31:0] target, input logic [1:0] sel, input string what);
	ctr_t exp_ctr;
	exp_ctr = model_ctr[{sel[1], fpc.f.index}];
	pc = fpc;
	tick();
	check_eq(32'(pred_valid), 32'(hit && !at_line_end(fpc)), {what, " valid"});
	check_eq(32'(pred_cf), 32'(cf), {what, " cf"});
	check_eq(32'(pred_sel), 32'(sel), {what, " sel"});
	check_eq(32'(pred_counter), 32'(exp_ctr), {what, " counter"});
	check_eq(32'(pred_taken), 32'(cf == cf_branch ? exp_ctr[1] : 1'b1), {what, " taken"});
	if (cf != cf_none)
		check_eq(pred_target, target, {what, " target"});
endtask

task automatic test_cold();
	vaddr_u a;
	repeat (16) begin
		a.raw = $random(seed);
		predict(a, 1'b0, cf_none, '0, 2'b10, "cold");
	end
endtask

task automatic test_training();
	vaddr_u      a;
	logic [31:0] t;
	make_pc(6'd5, 1'b0, a);
	t = $random(seed);
	repeat (4) begin
		resolve(a, t, cf_branch, 1'b1);
		predict(a, 1'b1, cf_branch, t, 2'b01, "train taken");
	end
	check_eq(32'(pred_counter), 32'd3, "counter saturated high");
	repeat (5) begin
		resolve(a, t, cf_branch, 1'b0);
		predict(a, 1'b1, cf_branch, t, 2'b01, "train not taken");
	end
	check_eq(32'(pred_counter), 32'd0, "counter saturated low");
endtask

task automatic test_lane_choice();
	vaddr_u      p0;
	vaddr_u      p1;
	vaddr_u      p2;
	logic [31:0] t0;
	logic [31:0] t1;
	logic [31:0] t2;
	make_pc(6'd10, 1'b0, p0);
	p1        = p0;
	p1.f.lane = 1'b1;
	make_pc(6'd12, 1'b1, p2);
	t0 = $random(seed);
	t1 = $random(seed);
	t2 = $random(seed);
	// jumps are predicted taken whatever the resolved outcome was
	resolve(p0, t0, cf_jump, 1'b0);
	resolve(p1, t1, cf_jump, 1'b1);
	resolve(p2, t2, cf_indirect, 1'b0);
	predict(p0, 1'b1, cf_jump, t0, 2'b01, "both lanes");
	predict(p1, 1'b1, cf_jump, t1, 2'b10, "odd slot");
	p2.f.lane = 1'b0;
	predict(p2, 1'b1, cf_indirect, t2, 2'b10, "lane 1 only");
	keep_pc     = p0;
	keep_target = t0;
endtask

task automatic test_aliasing();
	vaddr_u      a;
	vaddr_u      b;
	logic [31:0] ta;
	logic [31:0] tb;
	make_pc(6'd20, 1'b0, a);
	b       = a;
	b.f.tag = ~a.f.tag;
	ta = $random(seed);
	tb = $random(seed);
	resolve(a, ta, cf_jump, 1'b1);
	predict(b, 1'b0, cf_none, '0, 2'b10, "alias miss");
	resolve(b, tb, cf_indirect, 1'b1);
	predict(b, 1'b1, cf_indirect, tb, 2'b01, "alias replace");
	predict(a, 1'b0, cf_none, '0, 2'b10, "alias evicted");
	alias_pc     = b;
	alias_target = tb;
endtask

task automatic test_suppression();
	vaddr_u      a;
	vaddr_u      f;
	logic [31:0] t;
	// index 27 puts the pair at line offset 24
	make_pc(6'd27, 1'b1, a);
	t = $random(seed);
	resolve(a, t, cf_branch, 1'b1);
	resolve(a, t, cf_branch, 1'b1);
	predict(a, 1'b1, cf_branch, t, 2'b10, "line end");
	check_eq(32'(pred_valid), 32'd0, "line end suppressed");
	make_pc(6'd30, 1'b0, f);
	resolve(f, t, cf_jump, 1'b1);
	predict(f, 1'b1, cf_jump, t, 2'b01, "before flush");
	flush = 1'b1;
	tick();
	flush = 1'b0;
	check_eq(32'(pred_valid), 32'd0, "cycle after flush");
	predict(f, 1'b1, cf_jump, t, 2'b01, "after flush");
endtask

task automatic test_stall();
	logic [31:0] held_target;
	logic [7:0]  held_ctl;
	predict(keep_pc, 1'b1, cf_jump, keep_target, 2'b01, "before stall");
	held_target = pred_target;
	held_ctl    = {pred_valid, pred_taken, pred_cf, pred_counter, pred_sel};
	stall = 1'b1;
	repeat (3) begin
		pc.raw = $random(seed);
		tick();
		check_eq(pred_target, held_target, "stall target");
		check_eq(32'({pred_valid, pred_taken, pred_cf, pred_counter, pred_sel}),
			32'(held_ctl), "stall controls");
	end
	stall = 1'b0;
	predict(alias_pc, 1'b1, cf_indirect, alias_target, 2'b01, "after stall");
endtask

initial begin
	clk         = 1'b0;
	rst         = 1'b1;
	stall       = 1'b0;
	flush       = 1'b0;
	pc          = '0;
	res_valid   = 1'b0;
	res_pc      = '0;
	res_target  = '0;
	res_cf      = cf_none;
	res_taken   = 1'b0;
	res_counter = CTR_RESET;
	for (int i = 0; i < LANES*ENTRIES; i++)
		model_ctr[i] = CTR_RESET;
	repeat (5) @(posedge clk);
	#1;
	rst = 1'b0;
	test_cold();
	test_training();
	test_lane_choice();
	test_aliasing();
	test_suppression();
	test_stall();
	$display("Result: PASSED");
	$finish;
end

endmodule

//--- filelist.f
logic/bp_pkg.sv
logic/bp_update_router.sv
logic/bp_lane_bank.sv
logic/bp_select.sv
logic/branch_predictor.sv
dv/tb_branch_predictor.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f filelist.f --top-module tb_branch_predictor -Mdir obj_dir
	out=$$(./obj_dir/Vtb_branch_predictor); echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
